// File: switch_pkg.sv
package switch_pkg;

    ////////////////////
    // Sizes
    ////////////////////
    localparam int NUM_PORTS        = 4;
    localparam int PORT_IDX_W       = $clog2(NUM_PORTS);
    localparam int RX_QUEUE_BYTES   = 128;
    localparam int CAM_DEPTH        = 32;
    localparam int MAC_HEADER_BYTES = 12;

    // Derived widths
    localparam int RXQ_PTR_W = $clog2(RX_QUEUE_BYTES);
    localparam int RXQ_CNT_W = $clog2(RX_QUEUE_BYTES + 1);
    localparam int CAM_IDX_W = $clog2(CAM_DEPTH);
    localparam int HDR_IDX_W = $clog2(MAC_HEADER_BYTES);

    ////////////////////
    // Stream and address types
    ////////////////////
    typedef struct packed {
        logic [7:0] data;
        logic       last;
    } stream_beat_t;

    // First received byte sits in bits 47:40
    typedef logic [47:0]           mac_addr_t;
    typedef logic [PORT_IDX_W-1:0] port_idx_t;
    typedef logic [NUM_PORTS-1:0]  port_mask_t;

    ////////////////////
    // MAC table interface
    ////////////////////
    typedef struct packed {
        logic      valid;
        mac_addr_t lookup_key;
        mac_addr_t learn_key;
        port_idx_t learn_port;
    } cam_req_t;

    typedef struct packed {
        logic      valid;
        logic      hit;
        port_idx_t port;
    } cam_rsp_t;

endpackage

// File: port_rx_queue.sv
`timescale 1ns/1ps

module port_rx_queue (
    input  logic                     clock,
    input  logic                     arst_n,
    input  switch_pkg::stream_beat_t in_beat,
    input  logic                     in_valid,
    output logic                     in_ready,
    output switch_pkg::stream_beat_t head_beat,
    output logic                     frame_avail,
    input  logic                     pop
);

    switch_pkg::stream_beat_t mem [switch_pkg::RX_QUEUE_BYTES];

    logic [switch_pkg::RXQ_PTR_W-1:0] wr_ptr;
    logic [switch_pkg::RXQ_PTR_W-1:0] rd_ptr;
    logic [switch_pkg::RXQ_CNT_W-1:0] byte_count;
    logic [switch_pkg::RXQ_CNT_W-1:0] frame_count;

    logic push;
    logic pull;
    logic push_last;
    logic pull_last;

    assign in_ready  = (byte_count != switch_pkg::RXQ_CNT_W'(switch_pkg::RX_QUEUE_BYTES));
    assign push      = in_valid && in_ready;
    assign pull      = pop && (byte_count != '0);
    assign push_last = push && in_beat.last;
    assign pull_last = pull && head_beat.last;

    assign head_beat   = mem[rd_ptr];
    // Only whole frames are offered, so the orchestrator never stalls mid-frame
    assign frame_avail = (frame_count != '0);

    always_ff @(posedge clock) begin
        if (push) begin
            mem[wr_ptr] <= in_beat;
        end
    end

    always_ff @(posedge clock or negedge arst_n) begin
        if (!arst_n) begin
            wr_ptr      <= '0;
            rd_ptr      <= '0;
            byte_count  <= '0;
            frame_count <= '0;
        end else begin
            if (push) begin
                wr_ptr <= wr_ptr + 1'b1;
            end
            if (pull) begin
                rd_ptr <= rd_ptr + 1'b1;
            end

            case ({push, pull})
                2'b10:   byte_count <= byte_count + 1'b1;
                2'b01:   byte_count <= byte_count - 1'b1;
                default: byte_count <= byte_count;
            endcase

            // Complete frames held
            case ({push_last, pull_last})
                2'b10:   frame_count <= frame_count + 1'b1;
                2'b01:   frame_count <= frame_count - 1'b1;
                default: frame_count <= frame_count;
            endcase
        end
    end

endmodule

// File: mac_cam_table.sv
`timescale 1ns/1ps

module mac_cam_table (
    input  logic                 clock,
    input  logic                 arst_n,
    input  switch_pkg::cam_req_t req,
    output switch_pkg::cam_rsp_t rsp
);

    logic [switch_pkg::CAM_DEPTH-1:0] entry_valid;
    switch_pkg::mac_addr_t            entry_mac  [switch_pkg::CAM_DEPTH];
    switch_pkg::port_idx_t            entry_port [switch_pkg::CAM_DEPTH];

    logic [switch_pkg::CAM_IDX_W-1:0] replace_ptr;

    logic                             lookup_hit;
    switch_pkg::port_idx_t            lookup_port;
    logic                             learn_hit;
    logic [switch_pkg::CAM_IDX_W-1:0] learn_idx;
    logic [switch_pkg::CAM_IDX_W-1:0] write_idx;

    ////////////////////
    // Parallel compare
    ////////////////////
    always_comb begin
        lookup_hit  = 1'b0;
        lookup_port = '0;
        learn_hit   = 1'b0;
        learn_idx   = '0;
        for (int i = 0; i < switch_pkg::CAM_DEPTH; i++) begin
            if (entry_valid[i] && (entry_mac[i] == req.lookup_key)) begin
                lookup_hit  = 1'b1;
                lookup_port = entry_port[i];
            end
            if (entry_valid[i] && (entry_mac[i] == req.learn_key)) begin
                learn_hit = 1'b1;
                learn_idx = switch_pkg::CAM_IDX_W'(i);
            end
        end
    end

    // Known station is updated in place, new one goes to the oldest slot
    assign write_idx = learn_hit ? learn_idx : replace_ptr;

    always_ff @(posedge clock) begin
        if (req.valid) begin
            entry_mac[write_idx]  <= req.learn_key;
            entry_port[write_idx] <= req.learn_port;
        end
    end

    ////////////////////
    // Control and response
    ////////////////////
    always_ff @(posedge clock or negedge arst_n) begin
        if (!arst_n) begin
            rsp         <= '0;
            entry_valid <= '0;
            replace_ptr <= '0;
        end else begin
            rsp.valid <= req.valid;
            if (req.valid) begin
                rsp.hit  <= lookup_hit;
                rsp.port <= lookup_port;

                entry_valid[write_idx] <= 1'b1;
                if (!learn_hit) begin
                    if (replace_ptr == switch_pkg::CAM_IDX_W'(switch_pkg::CAM_DEPTH - 1)) begin
                        replace_ptr <= '0;
                    end else begin
                        replace_ptr <= replace_ptr + 1'b1;
                    end
                end
            end
        end
    end

endmodule

// File: frame_orchestrator.sv
`timescale 1ns/1ps

module frame_orchestrator (
    input  logic                                                clock,
    input  logic                                                arst_n,
    input  switch_pkg::stream_beat_t [switch_pkg::NUM_PORTS-1:0] head_beat,
    input  switch_pkg::port_mask_t                              frame_avail,
    output switch_pkg::port_mask_t                              pop,
    output switch_pkg::cam_req_t                                cam_req,
    input  switch_pkg::cam_rsp_t                                cam_rsp,
    output switch_pkg::stream_beat_t                            tx_beat,
    output switch_pkg::port_mask_t                              tx_valid
);

    typedef enum logic [2:0] {
        ST_IDLE,
        ST_HEADER,
        ST_LOOKUP,
        ST_SEND_HEADER,
        ST_SEND_BODY,
        ST_DRAIN
    } state_t;

    state_t                           state;
    switch_pkg::port_idx_t            cur_port;
    switch_pkg::port_idx_t            last_port;
    logic [switch_pkg::HDR_IDX_W-1:0] hdr_idx;
    logic                             frame_ended;
    logic                             lookup_issued;
    switch_pkg::port_mask_t           egress_mask;

    switch_pkg::stream_beat_t         hdr_buf [switch_pkg::MAC_HEADER_BYTES];

    logic                             grant_found;
    switch_pkg::port_idx_t            grant_port;
    switch_pkg::port_idx_t            cand_port;
    switch_pkg::mac_addr_t            dst_mac;
    switch_pkg::mac_addr_t            src_mac;
    switch_pkg::port_mask_t           rsp_mask;
    switch_pkg::stream_beat_t         cur_head;
    logic                             hdr_end;

    assign cur_head = head_beat[cur_port];
    assign hdr_end  = (hdr_idx == switch_pkg::HDR_IDX_W'(switch_pkg::MAC_HEADER_BYTES - 1));

    ////////////////////
    // Round-robin grant
    ////////////////////
    always_comb begin
        grant_found = 1'b0;
        grant_port  = last_port;
        cand_port   = last_port;
        for (int k = 1; k <= switch_pkg::NUM_PORTS; k++) begin
            cand_port = switch_pkg::port_idx_t'((int'(last_port) + k) % switch_pkg::NUM_PORTS);
            if (!grant_found && frame_avail[cand_port]) begin
                grant_found = 1'b1;
                grant_port  = cand_port;
            end
        end
    end

    // Destination then source
    always_comb begin
        for (int i = 0; i < 6; i++) begin
            dst_mac[47-8*i -: 8] = hdr_buf[i].data;
            src_mac[47-8*i -: 8] = hdr_buf[i+6].data;
        end
    end

    // Hit on ingress port filters the frame
    always_comb begin
        if (!cam_rsp.hit) begin
            rsp_mask = ~(switch_pkg::port_mask_t'(1) << cur_port);
        end else if (cam_rsp.port == cur_port) begin
            rsp_mask = '0;
        end else begin
            rsp_mask = switch_pkg::port_mask_t'(1) << cam_rsp.port;
        end
    end

    assign cam_req.valid      = (state == ST_LOOKUP) && !lookup_issued;
    assign cam_req.lookup_key = dst_mac;
    assign cam_req.learn_key  = src_mac;
    assign cam_req.learn_port = cur_port;

    always_comb begin
        pop      = '0;
        tx_valid = '0;
        tx_beat  = '0;
        case (state)
            ST_HEADER, ST_DRAIN: begin
                pop[cur_port] = 1'b1;
            end
            ST_SEND_HEADER: begin
                tx_beat  = hdr_buf[hdr_idx];
                tx_valid = egress_mask;
            end
            ST_SEND_BODY: begin
                pop[cur_port] = 1'b1;
                tx_beat       = cur_head;
                tx_valid      = egress_mask;
            end
            default: ;
        endcase
    end

    always_ff @(posedge clock) begin
        if (state == ST_HEADER) begin
            hdr_buf[hdr_idx] <= cur_head;
        end
    end

    ////////////////////
    // FSM
    ////////////////////
    always_ff @(posedge clock or negedge arst_n) begin
        if (!arst_n) begin
            state         <= ST_IDLE;
            cur_port      <= '0;
            last_port     <= switch_pkg::port_idx_t'(switch_pkg::NUM_PORTS - 1);
            hdr_idx       <= '0;
            frame_ended   <= 1'b0;
            lookup_issued <= 1'b0;
            egress_mask   <= '0;
        end else begin
            case (state)
                ST_IDLE: begin
                    hdr_idx     <= '0;
                    frame_ended <= 1'b0;
                    if (grant_found) begin
                        cur_port  <= grant_port;
                        last_port <= grant_port;
                        state     <= ST_HEADER;
                    end
                end
                ST_HEADER: begin
                    if (cur_head.last || hdr_end) begin
                        frame_ended   <= cur_head.last;
                        lookup_issued <= 1'b0;
                        state         <= ST_LOOKUP;
                    end else begin
                        hdr_idx <= hdr_idx + 1'b1;
                    end
                end
                ST_LOOKUP: begin
                    lookup_issued <= 1'b1;
                    hdr_idx       <= '0;
                    if (cam_rsp.valid) begin
                        egress_mask <= rsp_mask;
                        if (rsp_mask != '0) begin
                            state <= ST_SEND_HEADER;
                        end else if (frame_ended) begin
                            state <= ST_IDLE;
                        end else begin
                            state <= ST_DRAIN;
                        end
                    end
                end
                ST_SEND_HEADER: begin
                    if (hdr_buf[hdr_idx].last) begin
                        state <= ST_IDLE;
                    end else if (hdr_end) begin
                        state <= ST_SEND_BODY;
                    end else begin
                        hdr_idx <= hdr_idx + 1'b1;
                    end
                end
                ST_SEND_BODY, ST_DRAIN: begin
                    if (cur_head.last) begin
                        state <= ST_IDLE;
                    end
                end
                default: state <= ST_IDLE;
            endcase
        end
    end

endmodule

// File: switch_core.sv
`timescale 1ns/1ps

module switch_core (
    input  logic                                                clock,
    input  logic                                                arst_n,
    input  switch_pkg::stream_beat_t [switch_pkg::NUM_PORTS-1:0] rx_beat,
    input  switch_pkg::port_mask_t                              rx_valid,
    output switch_pkg::port_mask_t                              rx_ready,
    output switch_pkg::stream_beat_t                            tx_beat,
    output switch_pkg::port_mask_t                              tx_valid
);

    switch_pkg::stream_beat_t [switch_pkg::NUM_PORTS-1:0] head_beat;
    switch_pkg::port_mask_t                              frame_avail;
    switch_pkg::port_mask_t                              pop;
    switch_pkg::cam_req_t                                cam_req;
    switch_pkg::cam_rsp_t                                cam_rsp;

    ////////////////////
    // Receive queues
    ////////////////////
    for (genvar i = 0; i < switch_pkg::NUM_PORTS; i++) begin : gen_rx_queue
        port_rx_queue port_rx_queue_i (
            .clock       (clock),
            .arst_n      (arst_n),
            .in_beat     (rx_beat[i]),
            .in_valid    (rx_valid[i]),
            .in_ready    (rx_ready[i]),
            .head_beat   (head_beat[i]),
            .frame_avail (frame_avail[i]),
            .pop         (pop[i])
        );
    end

    ////////////////////
    // Forwarding
    ////////////////////
    frame_orchestrator frame_orchestrator_i (
        .clock       (clock),
        .arst_n      (arst_n),
        .head_beat   (head_beat),
        .frame_avail (frame_avail),
        .pop         (pop),
        .cam_req     (cam_req),
        .cam_rsp     (cam_rsp),
        .tx_beat     (tx_beat),
        .tx_valid    (tx_valid)
    );

    mac_cam_table mac_cam_table_i (
        .clock  (clock),
        .arst_n (arst_n),
        .req    (cam_req),
        .rsp    (cam_rsp)
    );

endmodule

// File: tb_switch_core.sv
`timescale 1ns/1ps

module tb_switch_core;

    localparam int FLOOD_LEN  = 14;
    localparam int TEST_BYTES = 40 + 30 + 50 + 25 + 35 + 20 + 60 + 8 * 24
                              + (switch_pkg::CAM_DEPTH + 1) * FLOOD_LEN + 2 * 20;
    localparam int TIMEOUT_CYCLES = 4 * switch_pkg::NUM_PORTS * TEST_BYTES + 2000;

    logic                                                clock;
    logic                                                arst_n;
    switch_pkg::stream_beat_t [switch_pkg::NUM_PORTS-1:0] rx_beat;
    switch_pkg::port_mask_t                              rx_valid;
    switch_pkg::port_mask_t                              rx_ready;
    switch_pkg::stream_beat_t                            tx_beat;
    switch_pkg::port_mask_t                              tx_valid;

    // Frame bytes packed with byte 0 in bits 7:0
    logic [1023:0]          pend_data [$];
    int                     pend_len  [$];
    switch_pkg::port_mask_t pend_mask [$];
    logic [1023:0]          out_data  [$];
    int                     out_len   [$];
    switch_pkg::port_mask_t out_mask  [$];
    logic [1023:0]          cur_data;
    int                     cur_len;
    switch_pkg::port_mask_t cur_mask;

    switch_pkg::mac_addr_t  model_mac   [switch_pkg::CAM_DEPTH];
    switch_pkg::port_idx_t  model_port  [switch_pkg::CAM_DEPTH];
    bit                     model_valid [switch_pkg::CAM_DEPTH];
    int                     model_ptr;
    int                     cycle_count;

    switch_core dut_i (
        .clock    (clock),
        .arst_n   (arst_n),
        .rx_beat  (rx_beat),
        .rx_valid (rx_valid),
        .rx_ready (rx_ready),
        .tx_beat  (tx_beat),
        .tx_valid (tx_valid)
    );

    initial begin
        clock = 1'b0;
        forever #2 clock = ~clock;
    end

    initial begin
        cycle_count = 0;
        while (cycle_count < TIMEOUT_CYCLES) begin
            @(posedge clock);
            cycle_count++;
        end
        $display("Timeout: the run did not finish within %0d cycles", TIMEOUT_CYCLES);
        $display("TEST RESULT: FAIL");
        $fatal(1, "timeout");
    end

    task automatic check(input string name, input logic [63:0] expected,
                         input logic [63:0] actual);
        if (expected !== actual) begin
            $display("ERROR %s: expected %0h actual %0h", name, expected, actual);
            $display("TEST RESULT: FAIL");
            $fatal(1, "value mismatch");
        end
    endtask

    function automatic switch_pkg::mac_addr_t station(input int id);
        return {16'h0200, 32'(id)};
    endfunction

    ////////////////////
    // Reference MAC table
    ////////////////////
    function automatic switch_pkg::port_mask_t model_forward(input switch_pkg::port_idx_t ingress,
            input switch_pkg::mac_addr_t dst, input switch_pkg::mac_addr_t src);
        logic                   hit;
        switch_pkg::port_idx_t  hit_port;
        switch_pkg::port_mask_t mask;
        int                     slot;
        hit      = 1'b0;
        hit_port = '0;
        slot     = -1;
        for (int i = 0; i < switch_pkg::CAM_DEPTH; i++) begin
            if (model_valid[i] && model_mac[i] == dst) begin
                hit      = 1'b1;
                hit_port = model_port[i];
            end
            if (model_valid[i] && model_mac[i] == src) begin
                slot = i;
            end
        end
        if (!hit) begin
            mask = ~(switch_pkg::port_mask_t'(1) << ingress);
        end else if (hit_port == ingress) begin
            mask = '0;
        end else begin
            mask = switch_pkg::port_mask_t'(1) << hit_port;
        end
        // New station takes the oldest slot
        if (slot < 0) begin
            slot      = model_ptr;
            model_ptr = (model_ptr + 1) % switch_pkg::CAM_DEPTH;
        end
        model_valid[slot] = 1'b1;
        model_mac[slot]   = src;
        model_port[slot]  = ingress;
        return mask;
    endfunction

    task automatic send_frame(input int port, input switch_pkg::mac_addr_t dst,
                              input switch_pkg::mac_addr_t src, input int length);
        logic [1023:0]          data;
        switch_pkg::port_mask_t mask;
        data = '0;
        for (int i = 0; i < 6; i++) begin
            data[8*i +: 8]     = dst[47-8*i -: 8];
            data[8*(i+6) +: 8] = src[47-8*i -: 8];
        end
        for (int i = 12; i < length; i++) begin
            data[8*i +: 8] = 8'($urandom);
        end
        mask = model_forward(switch_pkg::port_idx_t'(port), dst, src);
        if (mask != '0) begin
            pend_data.push_back(data);
            pend_len.push_back(length);
            pend_mask.push_back(mask);
        end
        @(posedge clock);
        #0.5;
        for (int i = 0; i < length; i++) begin
            rx_beat[port].data = data[8*i +: 8];
            rx_beat[port].last = (i == length - 1);
            rx_valid[port]     = 1'b1;
            @(negedge clock);
            while (!rx_ready[port]) begin
                @(negedge clock);
            end
            @(posedge clock);
            #0.5;
        end
        rx_valid[port] = 1'b0;
        rx_beat[port]  = '0;
    endtask

    // Output frames are matched by mask, so per-port order still holds
    task automatic expect_frame(input string name);
        logic [1023:0]          act;
        int                     len;
        switch_pkg::port_mask_t mask;
        int                     idx;
        while (out_mask.size() == 0) begin
            @(negedge clock);
        end
        act  = out_data.pop_front();
        len  = out_len.pop_front();
        mask = out_mask.pop_front();
        idx  = -1;
        for (int j = 0; j < pend_mask.size(); j++) begin
            if (idx < 0 && pend_mask[j] == mask) begin
                idx = j;
            end
        end
        if (idx < 0) begin
            $display("%s: an output frame with mask %b was not expected", name, mask);
            $display("TEST RESULT: FAIL");
            $fatal(1, "unexpected frame");
        end
        check({name, " length"}, pend_len[idx], len);
        for (int i = 0; i < len; i++) begin
            check({name, " byte"}, pend_data[idx][8*i +: 8], act[8*i +: 8]);
        end
        pend_data.delete(idx);
        pend_len.delete(idx);
        pend_mask.delete(idx);
    endtask

    always @(negedge clock) begin
        if (tx_valid != '0) begin
            if (cur_len == 0) begin
                cur_mask = tx_valid;
                cur_data = '0;
            end
            check("monitor mask", cur_mask, tx_valid);
            cur_data[8*cur_len +: 8] = tx_beat.data;
            cur_len++;
            if (tx_beat.last) begin
                out_data.push_back(cur_data);
                out_len.push_back(cur_len);
                out_mask.push_back(cur_mask);
                cur_len = 0;
            end
        end else if (cur_len != 0) begin
            $display("Monitor: an output frame paused before its last byte");
            $display("TEST RESULT: FAIL");
            $fatal(1, "frame gap");
        end
    end

    ////////////////////
    // Directed tests
    ////////////////////
    task automatic send_two(input int port, input switch_pkg::mac_addr_t dst,
                            input switch_pkg::mac_addr_t src);
        send_frame(port, dst, src, 24);
        send_frame(port, dst, src, 24);
    endtask

    task automatic test_flooding();
        send_frame(0, 48'h0300_0000_ffff, station(1), 40);
        expect_frame("flooding");
    endtask

    task automatic test_learned_forwarding();
        send_frame(2, station(1), station(5), 30);
        expect_frame("learned_forwarding");
        send_frame(1, station(5), station(2), 50);
        expect_frame("learned_forwarding");
    endtask

    // Dropped frame must leave no trace before the next one
    task automatic test_same_port_filter();
        send_frame(2, station(5), station(3), 25);
        send_frame(3, station(5), station(4), 35);
        expect_frame("same_port_filter");
    endtask

    task automatic test_station_move();
        send_frame(3, station(1), station(5), 20);
        expect_frame("station_move");
        send_frame(0, station(5), station(1), 60);
        expect_frame("station_move");
    endtask

    task automatic test_concurrency();
        fork
            send_two(0, station(2), station(1));
            send_two(1, station(3), station(2));
            send_two(2, station(5), station(3));
            send_two(3, station(1), station(5));
        join
        for (int i = 0; i < 8; i++) begin
            expect_frame("concurrency");
        end
    endtask

    task automatic test_table_replacement();
        for (int i = 0; i <= switch_pkg::CAM_DEPTH; i++) begin
            send_frame(1, 48'h0300_0000_ffff, station(100 + i), FLOOD_LEN);
            expect_frame("table_fill");
        end
        send_frame(0, station(100 + switch_pkg::CAM_DEPTH),
                   station(99 + switch_pkg::CAM_DEPTH), 20);
        expect_frame("table_newest");
        // Station 1 was the oldest entry
        send_frame(2, station(1), station(98 + switch_pkg::CAM_DEPTH), 20);
        while (out_mask.size() == 0) begin
            @(negedge clock);
        end
        check("table_evicted mask", 4'b1011, out_mask[0]);
        expect_frame("table_evicted");
    endtask

    initial begin
        void'($urandom(32'ha43d_0b80));
        arst_n   = 1'b0;
        rx_beat  = '0;
        rx_valid = '0;
        cur_len  = 0;
        cur_data = '0;
        cur_mask = '0;
        for (int i = 0; i < switch_pkg::CAM_DEPTH; i++) begin
            model_valid[i] = 1'b0;
            model_mac[i]   = '0;
            model_port[i]  = '0;
        end
        model_ptr = 0;
        repeat (10) @(posedge clock);
        #0.5;
        arst_n = 1'b1;
        check("reset tx_valid", 0, tx_valid);
        check("reset rx_ready", {switch_pkg::NUM_PORTS{1'b1}}, rx_ready);
        check("reset cam_rsp", 0, dut_i.cam_rsp.valid);

        test_flooding();
        test_learned_forwarding();
        test_same_port_filter();
        test_station_move();
        test_concurrency();
        test_table_replacement();

        repeat (200) @(posedge clock);
        check("leftover output frames", 0, out_mask.size());
        check("missing output frames", 0, pend_mask.size());
        $display("TEST RESULT: PASS");
        $finish;
    end

endmodule

// File: project.f
switch_pkg.sv
port_rx_queue.sv
mac_cam_table.sv
frame_orchestrator.sv
switch_core.sv
tb_switch_core.sv

// File: Makefile
VERILATOR ?= verilator
TOP       ?= tb_switch_core
LOG       ?= sim.log
FLAGS     ?= --binary --timing -j 0
OBJ_DIR   ?= obj_dir
FILELIST  ?= project.f

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) --lint-only --timing --top-module $(TOP) -f $(FILELIST)

sim:
	$(VERILATOR) $(FLAGS) --top-module $(TOP) -Mdir $(OBJ_DIR) -f $(FILELIST)
	-./$(OBJ_DIR)/V$(TOP) > $(LOG) 2>&1
	@cat $(LOG)
	@grep -q "TEST RESULT: PASS" $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)
